// ==== flist.f ====
image_pkg.sv
mem_bus_if.sv
image_loader.sv
frame_arbiter.sv
frame_mem.sv
image_frame_top.sv
tb_image_frame.sv

// ==== frame_arbiter.sv ====
module frame_arbiter import image_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sel,
    input  logic        wr,
    input  row_t        row,
    input  col_t        col,
    input  pixel_t      wdata,
    input  logic        load_done,
    output pixel_t      rdata,
    output logic        rd_valid,
    mem_bus_if.arbiter   load_bus,
    mem_bus_if.requester mem_bus
);

    bus_owner_t owner;
    logic       in_range;
    logic       host_rd;
    logic       host_wr_ok;

    assign in_range   = (row < row_t'(IMG_ROWS)) && (col < col_t'(IMG_COLS));
    assign host_rd    = sel && !wr;
    // writes only land on a fully loaded frame
    assign host_wr_ok = sel && wr && load_done && in_range;

    //**************************************************
    // ownership, host first
    //**************************************************
    always_comb
    begin
        if (sel)
            owner = OWN_HOST;
        else if (load_bus.req)
            owner = OWN_LOADER;
        else
            owner = OWN_NONE;
    end

    assign load_bus.grant = (owner == OWN_LOADER);
    assign load_bus.rdata = mem_bus.rdata;

    // out-of-range host addresses never reach the array
    always_comb
    begin
        case (owner)
            OWN_HOST:
            begin
                mem_bus.req   = in_range;
                mem_bus.we    = host_wr_ok;
                mem_bus.row   = in_range ? row : '0;
                mem_bus.col   = in_range ? col : '0;
                mem_bus.wdata = wdata;
            end
            OWN_LOADER:
            begin
                mem_bus.req   = 1'b1;
                mem_bus.we    = load_bus.we;
                mem_bus.row   = load_bus.row;
                mem_bus.col   = load_bus.col;
                mem_bus.wdata = load_bus.wdata;
            end
            default:
            begin
                mem_bus.req   = 1'b0;
                mem_bus.we    = 1'b0;
                mem_bus.row   = '0;
                mem_bus.col   = '0;
                mem_bus.wdata = '0;
            end
        endcase
    end

    //**************************************************
    // read return, one cycle after the strobe
    //**************************************************
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_valid <= 1'b0;
            rdata    <= '0;
        end
        else
        begin
            rd_valid <= host_rd;
            rdata    <= (host_rd && in_range) ? mem_bus.rdata : '0;
        end
    end

    // a stalled loader retries the same pixel
    a_retry: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_bus.req && !load_bus.grant |=>
            load_bus.req && $stable(load_bus.row) && $stable(load_bus.col)
    );

endmodule

// ==== frame_mem.sv ====
module frame_mem import image_pkg::*;
(
    input logic       clk,
    mem_bus_if.memory bus
);

    //**************************************************
    // 28x28 pixel array
    //**************************************************
    pixel_t pixels [IMG_ROWS][IMG_COLS];

    // single write port, enabled by req
    always_ff @(posedge clk)
    begin
        if (bus.req && bus.we)
        begin
            pixels[bus.row][bus.col] <= bus.wdata;
        end
    end

    // async read, registered in the arbiter
    assign bus.rdata = pixels[bus.row][bus.col];

    // one port, no wait states
    assign bus.grant = 1'b1;

    // the arbiter keeps writes inside the frame
    a_wr_in_frame: assert property (
        @(posedge clk)
        bus.req && bus.we |-> (bus.row < row_t'(IMG_ROWS)) && (bus.col < col_t'(IMG_COLS))
    );

endmodule

// ==== image_frame_top.sv ====
module image_frame_top import image_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   sel,
    input  logic   wr,
    input  row_t   row,
    input  col_t   col,
    input  pixel_t wdata,
    output pixel_t rdata,
    output logic   rd_valid,
    output logic   load_done
);

    // loader to arbiter
    mem_bus_if load_bus ();
    // arbiter to storage
    mem_bus_if mem_bus ();

    //**************************************************
    // initial image copy
    //**************************************************
    image_loader u_image_loader (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (load_bus.requester),
        .load_done (load_done)
    );

    //**************************************************
    // host and loader share one port
    //**************************************************
    frame_arbiter u_frame_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (sel),
        .wr        (wr),
        .row       (row),
        .col       (col),
        .wdata     (wdata),
        .load_done (load_done),
        .rdata     (rdata),
        .rd_valid  (rd_valid),
        .load_bus  (load_bus.arbiter),
        .mem_bus   (mem_bus.requester)
    );

    //**************************************************
    // frame storage
    //**************************************************
    frame_mem u_frame_mem (
        .clk (clk),
        .bus (mem_bus.memory)
    );

endmodule

// ==== image_init.hex ====
// 28 rows of 28 signed pixels, two hex digits per pixel, row 0 first
00 FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 40
01 FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 41
02 FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 42
03 FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 43
04 FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 44
05 FA FA FA FA FA FA 37 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 37 00 0E 23 37 7F 80 F1 45
06 FA FA FA FA FA FA 37 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 37 00 0E 23 37 7F 80 F1 46
07 FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 00 23 7F 23 0E 23 37 7F 80 F1 47
08 FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 00 23 7F 23 0E 23 37 7F 80 F1 48
09 FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 23 7F 23 00 0E 23 37 7F 80 F1 49
0A FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 23 7F 23 00 0E 23 37 7F 80 F1 4A
0B FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 23 7F 23 00 00 0E 23 37 7F 80 F1 4B
0C FA FA FA FA FA FA 00 00 00 00 00 00 00 00 23 7F 23 00 00 00 0E 23 37 7F 80 F1 4C
0D FA FA FA FA FA FA 00 00 00 00 00 00 00 00 23 7F 23 00 00 00 0E 23 37 7F 80 F1 4D
0E FA FA FA FA FA FA 00 00 00 00 00 00 00 23 7F 23 00 00 00 00 0E 23 37 7F 80 F1 4E
0F FA FA FA FA FA FA 00 00 00 00 00 00 23 7F 23 00 00 00 00 00 0E 23 37 7F 80 F1 4F
10 FA FA FA FA FA FA 00 00 00 00 00 00 23 7F 23 00 00 00 00 00 0E 23 37 7F 80 F1 50
11 FA FA FA FA FA FA 00 00 00 00 00 23 7F 23 00 00 00 00 00 00 0E 23 37 7F 80 F1 51
12 FA FA FA FA FA FA 00 00 00 00 23 7F 23 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 52
13 FA FA FA FA FA FA 00 00 00 00 23 7F 23 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 53
14 FA FA FA FA FA FA 00 00 00 23 7F 23 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 54
15 FA FA FA FA FA FA 00 00 23 7F 23 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 55
16 FA FA FA FA FA FA 00 00 23 7F 23 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 56
17 FA FA FA FA FA FA 00 23 7F 23 00 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 57
18 FA FA FA FA FA FA 23 7F 23 00 00 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 58
19 FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 59
1A FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 5A
1B FA FA FA FA FA FA 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0E 23 37 7F 80 F1 5B

// ==== image_loader.sv ====
module image_loader import image_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    mem_bus_if.requester bus,
    output logic        load_done
);

    typedef logic [$clog2(IMG_PIXELS)-1:0] idx_t;

    //**************************************************
    // built-in image
    //**************************************************
    pixel_t image_rom [IMG_PIXELS];

    initial
    begin
        $readmemh(IMG_INIT_FILE, image_rom);
    end

    //**************************************************
    // copy FSM
    //**************************************************
    loader_state_t state;
    row_t          row_cnt;
    col_t          col_cnt;
    idx_t          pix_idx;
    logic          last_pix;

    assign last_pix = (pix_idx == idx_t'(IMG_PIXELS - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= LD_COPY;
            row_cnt <= '0;
            col_cnt <= '0;
            pix_idx <= '0;
        end
        else
        begin
            case (state)
                LD_COPY, LD_STALL:
                begin
                    if (!bus.grant)
                    begin
                        // host has the port, hold this pixel
                        state <= LD_STALL;
                    end
                    else if (last_pix)
                    begin
                        state <= LD_DONE;
                    end
                    else
                    begin
                        state   <= LD_COPY;
                        pix_idx <= pix_idx + idx_t'(1);
                        if (col_cnt == col_t'(IMG_COLS - 1))
                        begin
                            col_cnt <= '0;
                            row_cnt <= row_cnt + row_t'(1);
                        end
                        else
                        begin
                            col_cnt <= col_cnt + col_t'(1);
                        end
                    end
                end
                default:
                begin
                    state <= LD_DONE;
                end
            endcase
        end
    end

    // one write per cycle until the frame is full
    assign bus.req   = (state != LD_DONE);
    assign bus.we    = (state != LD_DONE);
    assign bus.row   = row_cnt;
    assign bus.col   = col_cnt;
    assign bus.wdata = image_rom[pix_idx];

    assign load_done = (state == LD_DONE);

    // walk ends on the last raster position
    a_done_at_end: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == LD_DONE) |->
            (row_cnt == row_t'(IMG_ROWS - 1)) && (col_cnt == col_t'(IMG_COLS - 1))
    );

endmodule

// ==== image_pkg.sv ====
package image_pkg;

    //**************************************************
    // image geometry
    //**************************************************
    localparam int IMG_ROWS   = 28;
    localparam int IMG_COLS   = 28;
    localparam int IMG_PIXELS = IMG_ROWS * IMG_COLS;
    localparam int PIX_W      = 8;

    // raster-order initial image, one row of bytes per line
    localparam string IMG_INIT_FILE = "image_init.hex";

    //**************************************************
    // data types
    //**************************************************
    // quantized activation, two's complement
    typedef logic signed [PIX_W-1:0] pixel_t;

    // 5 bits reach 31, enough for 0..27
    typedef logic [4:0] row_t;
    typedef logic [4:0] col_t;

    // loader FSM
    typedef enum logic [1:0] {
        LD_COPY,
        LD_STALL,
        LD_DONE
    } loader_state_t;

    // who used the memory port this cycle
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_LOADER,
        OWN_HOST
    } bus_owner_t;

endpackage

// ==== mem_bus_if.sv ====
interface mem_bus_if import image_pkg::*;
();

    // request side
    logic   req;
    logic   we;
    row_t   row;
    col_t   col;
    pixel_t wdata;

    // response side
    pixel_t rdata;
    logic   grant;

    // issues accesses, waits on grant
    modport requester (
        output req,
        output we,
        output row,
        output col,
        output wdata,
        input  rdata,
        input  grant
    );

    // decides who gets the port
    modport arbiter (
        input  req,
        input  we,
        input  row,
        input  col,
        input  wdata,
        output rdata,
        output grant
    );

    // storage end, req acts as enable
    modport memory (
        input  req,
        input  we,
        input  row,
        input  col,
        input  wdata,
        output rdata,
        output grant
    );

endinterface

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
    --top-module tb_image_frame -f flist.f -o sim_image_frame

./obj_dir/sim_image_frame | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== tb_image_frame.sv ====
module tb_image_frame import image_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   sel;
    logic   wr;
    row_t   row;
    col_t   col;
    pixel_t wdata;
    pixel_t rdata;
    logic   rd_valid;
    logic   load_done;

    // expected frame, kept in step with accepted host writes
    pixel_t model [IMG_PIXELS];
    pixel_t exp_q [$];
    bit     chk_q [$];
    string  name_q [$];
    pixel_t exp_val;
    bit     exp_chk;
    string  exp_name;
    string  test_name;
    int     errors;
    int     reads_issued;
    int     reads_seen;
    int     seed;
    bit     timed_out;

    always #2 clk = ~clk;

    image_frame_top u_image_frame_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (sel),
        .wr        (wr),
        .row       (row),
        .col       (col),
        .wdata     (wdata),
        .rdata     (rdata),
        .rd_valid  (rd_valid),
        .load_done (load_done)
    );

    //**************************************************
    // reference model and compare tasks
    //**************************************************
    function automatic bit in_frame(row_t r, col_t c);
        return (int'(r) < IMG_ROWS) && (int'(c) < IMG_COLS);
    endfunction

    // off-frame coordinates read back as zero
    function automatic pixel_t ref_pixel(row_t r, col_t c);
        if (!in_frame(r, c))
            return '0;
        return model[int'(r) * IMG_COLS + int'(c)];
    endfunction

    function automatic int rand_below(int n);
        return {$random(seed)} % n;
    endfunction

    task automatic check_pixel(string what, pixel_t expected, pixel_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", what, expected, actual);
        end
    endtask

    task automatic check_flag(string what, logic expected, logic actual);
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", what, expected, actual);
        end
    endtask

    task automatic check_count(string what, int expected, int actual);
        if (actual != expected)
        begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", what, expected, actual);
        end
    endtask

    // every read return is matched against the value queued at its strobe
    always @(negedge clk)
    begin
        if (rst_n && rd_valid)
        begin
            reads_seen++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("rd_valid pulsed with no read outstanding in %s", test_name);
            end
            else
            begin
                exp_val  = exp_q.pop_front();
                exp_chk  = chk_q.pop_front();
                exp_name = name_q.pop_front();
                if (exp_chk)
                    check_pixel(exp_name, exp_val, rdata);
            end
        end
        else if (rst_n)
        begin
            check_pixel({test_name, " idle rdata"}, '0, rdata);
        end
    end

    //**************************************************
    // host port stimulus, driven on the falling edge
    //**************************************************
    task automatic host_idle();
        @(negedge clk);
        sel = 1'b0;
        wr  = 1'b0;
    endtask

    task automatic host_write(row_t r, col_t c, pixel_t d);
        @(negedge clk);
        sel   = 1'b1;
        wr    = 1'b1;
        row   = r;
        col   = c;
        wdata = d;
        // dropped before load_done and off the frame
        if (load_done && in_frame(r, c))
            model[int'(r) * IMG_COLS + int'(c)] = d;
    endtask

    task automatic host_read(row_t r, col_t c, bit checked);
        @(negedge clk);
        sel = 1'b1;
        wr  = 1'b0;
        row = r;
        col = c;
        exp_q.push_back(ref_pixel(r, c));
        chk_q.push_back(checked);
        name_q.push_back($sformatf("%s (%0d,%0d)", test_name, r, c));
        reads_issued++;
    endtask

    task automatic drain_reads();
        int n;
        n = 0;
        host_idle();
        while (exp_q.size() != 0 && n < 8)
        begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            timed_out = 1'b1;
            $display("timeout: %0d reads in %s never got rd_valid", exp_q.size(), test_name);
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        sel   = 1'b0;
        wr    = 1'b0;
        for (int i = 0; i < 10; i++)
        begin
            @(negedge clk);
            check_flag({test_name, " load_done in reset"}, 1'b0, load_done);
            check_flag({test_name, " rd_valid in reset"}, 1'b0, rd_valid);
            check_pixel({test_name, " rdata in reset"}, '0, rdata);
        end
        rst_n = 1'b1;
    endtask

    task automatic wait_load(int limit, output int cycles);
        cycles = 0;
        while (!load_done && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!load_done)
        begin
            timed_out = 1'b1;
            $display("timeout: load_done still low after %0d cycles", cycles);
        end
    endtask

    task automatic read_frame();
        for (int r = 0; r < IMG_ROWS; r++)
        begin
            for (int c = 0; c < IMG_COLS; c++)
                host_read(row_t'(r), col_t'(c), 1'b1);
        end
        drain_reads();
        check_flag({test_name, " load_done held"}, 1'b1, load_done);
    endtask

    //**************************************************
    // test sequences
    //**************************************************
    task automatic test_clean_load();
        int cycles;
        test_name = "clean_load";
        @(negedge clk);
        check_flag({test_name, " load_done after reset"}, 1'b0, load_done);
        check_flag({test_name, " rd_valid after reset"}, 1'b0, rd_valid);
        check_pixel({test_name, " rdata after reset"}, '0, rdata);
        wait_load(800, cycles);
        if (timed_out)
            return;
        check_count({test_name, " load cycles"}, IMG_PIXELS, cycles + 1);
        read_frame();
    endtask

    task automatic test_write_readback();
        row_t rows [200];
        col_t cols [200];
        row_t r;
        col_t c;
        test_name = "write_readback";
        for (int i = 0; i < 200; i++)
        begin
            rows[i] = row_t'(rand_below(IMG_ROWS));
            cols[i] = col_t'(rand_below(IMG_COLS));
            host_write(rows[i], cols[i], pixel_t'($random(seed)));
        end
        for (int i = 0; i < 200; i++)
            host_read(rows[i], cols[i], 1'b1);
        test_name = "write_then_read";
        for (int i = 0; i < 20; i++)
        begin
            r = row_t'(rand_below(IMG_ROWS));
            c = col_t'(rand_below(IMG_COLS));
            host_write(r, c, pixel_t'($random(seed)));
            host_read(r, c, 1'b1);
        end
        drain_reads();
    endtask

    task automatic test_out_of_range();
        row_t r;
        col_t c;
        test_name = "out_of_range";
        for (int i = 0; i < 16; i++)
        begin
            r = (i % 2 == 0) ? row_t'(IMG_ROWS + rand_below(4)) : row_t'(rand_below(32));
            c = (i % 2 == 0) ? col_t'(rand_below(32)) : col_t'(IMG_COLS + rand_below(4));
            host_write(r, c, pixel_t'($random(seed)));
            host_read(r, c, 1'b1);
        end
        drain_reads();
        if (!timed_out)
            read_frame();
    endtask

    task automatic test_load_traffic();
        int cycles;
        int op;
        int issued_before;
        int seen_before;
        test_name = "load_traffic";
        apply_reset();
        $readmemh(IMG_INIT_FILE, model);
        issued_before = reads_issued;
        seen_before   = reads_seen;
        cycles        = 0;
        // host traffic only while the loader is still busy
        while (!load_done && cycles < 4000)
        begin
            op = rand_below(4);
            if (op == 0)
                host_read(row_t'(rand_below(32)), col_t'(rand_below(32)), 1'b0);
            else if (op == 1)
                host_write(row_t'(rand_below(32)), col_t'(rand_below(32)),
                           pixel_t'($random(seed)));
            else
                host_idle();
            cycles++;
        end
        if (!load_done)
        begin
            timed_out = 1'b1;
            $display("timeout: load under host traffic not done after %0d cycles", cycles);
            return;
        end
        drain_reads();
        if (timed_out)
            return;
        check_count({test_name, " reads answered"}, reads_issued - issued_before,
                    reads_seen - seen_before);
        read_frame();
    endtask

    initial
    begin
        rst_n        = 1'b0;
        sel          = 1'b0;
        wr           = 1'b0;
        row          = '0;
        col          = '0;
        wdata        = '0;
        errors       = 0;
        reads_issued = 0;
        reads_seen   = 0;
        timed_out    = 1'b0;
        seed         = 48;
        test_name    = "reset";
        $readmemh(IMG_INIT_FILE, model);
        apply_reset();
        test_clean_load();
        if (!timed_out)
            test_write_readback();
        if (!timed_out)
            test_out_of_range();
        if (!timed_out)
            test_load_traffic();
        $display("errors: %0d, reads seen: %0d, timeouts: %0d", errors, reads_seen, timed_out);
        if (errors == 0 && !timed_out)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
